// File: verilog/mipsPkg.sv
package mipsPkg;

   //////////////////////////////////////////////////
   // Sizes
   //////////////////////////////////////////////////
   localparam int dataWidth    = 32;
   localparam int imemDepth    = 64;
   localparam int dmemDepth    = 64;
   localparam int memAddrWidth = 6;

   // Primary opcodes
   localparam logic [5:0] opRType = 6'h00;
   localparam logic [5:0] opAddiu = 6'h09;
   localparam logic [5:0] opLw    = 6'h23;
   localparam logic [5:0] opSw    = 6'h2b;
   localparam logic [5:0] opBeq   = 6'h04;

   // R-type function codes
   localparam logic [5:0] fnAddu = 6'h21;
   localparam logic [5:0] fnSubu = 6'h23;
   localparam logic [5:0] fnAnd  = 6'h24;
   localparam logic [5:0] fnOr   = 6'h25;
   localparam logic [5:0] fnSlt  = 6'h2a;

   // Operand source selects for the forwarding muxes
   localparam logic [1:0] fwdSrcReg = 2'b00;
   localparam logic [1:0] fwdSrcMem = 2'b01;
   localparam logic [1:0] fwdSrcWb  = 2'b10;

   typedef enum logic [2:0] {
      aluAdd = 3'd0,
      aluSub = 3'd1,
      aluAnd = 3'd2,
      aluOr  = 3'd3,
      aluSlt = 3'd4
   } aluOpT;

   //////////////////////////////////////////////////
   // Control and stage payloads
   //////////////////////////////////////////////////
   typedef struct packed {
      logic  regWrite;
      logic  memRead;
      logic  memWrite;
      logic  memToReg;
      logic  aluSrcImm;
      logic  regDstRd;
      logic  isBranch;
      aluOpT aluOp;
   } ctrlT;

   typedef struct packed {
      logic [dataWidth-1:0] pcPlus4;
      logic [dataWidth-1:0] instr;
   } ifIdT;

   typedef struct packed {
      ctrlT                 ctrl;
      logic [dataWidth-1:0] pcPlus4;
      logic [dataWidth-1:0] rsVal;
      logic [dataWidth-1:0] rtVal;
      logic [dataWidth-1:0] imm;
      logic [4:0]           rs;
      logic [4:0]           rt;
      logic [4:0]           rd;
   } idExT;

   typedef struct packed {
      ctrlT                 ctrl;
      logic [dataWidth-1:0] aluResult;
      logic [dataWidth-1:0] storeData;
      logic [4:0]           destReg;
   } exMemT;

   typedef struct packed {
      logic                 regWrite;
      logic                 memToReg;
      logic [dataWidth-1:0] aluResult;
      logic [dataWidth-1:0] loadData;
      logic [4:0]           destReg;
   } memWbT;

endpackage

// File: verilog/pipeReg.sv
`timescale 1ns/1ps

module pipeReg import mipsPkg::*; #(
   parameter type payloadT = ifIdT
) (
   input  logic    Clk,
   input  logic    rstN,
   input  logic    stall,
   input  logic    flush,
   input  payloadT d,
   output payloadT q
);

   // Zero payload is a bubble, flush wins over stall
   always_ff @(posedge Clk) begin
      if (!rstN || flush) begin
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

// File: verilog/fetchStage.sv
`timescale 1ns/1ps

module fetchStage import mipsPkg::*; (
   input  logic                    Clk,
   input  logic                    rstN,
   input  logic                    pcStall,
   input  logic                    branchTaken,
   input  logic [dataWidth-1:0]    branchTarget,
   input  logic                    progWe,
   input  logic [memAddrWidth-1:0] progAddr,
   input  logic [dataWidth-1:0]    progData,
   output logic [dataWidth-1:0]    pc,
   output logic [dataWidth-1:0]    pcPlus4,
   output logic [dataWidth-1:0]    instr
);

   logic [dataWidth-1:0] imem [imemDepth];
   logic [dataWidth-1:0] nextPc;

   // Program load, only while the core sits in reset
   always_ff @(posedge Clk) begin
      if (progWe) begin
         imem[progAddr] <= progData;
      end
   end

   assign pcPlus4 = pc + 32'd4;
   assign instr   = imem[pc[memAddrWidth+1:2]];

   // Redirect beats a stall
   always_comb begin
      if (branchTaken) begin
         nextPc = branchTarget;
      end else if (pcStall) begin
         nextPc = pc;
      end else begin
         nextPc = pcPlus4;
      end
   end

   always_ff @(posedge Clk) begin
      if (!rstN) begin
         pc <= '0;
      end else begin
         pc <= nextPc;
      end
   end

endmodule

// File: verilog/decodeUnit.sv
`timescale 1ns/1ps

module decodeUnit import mipsPkg::*; (
   input  logic [dataWidth-1:0] instr,
   output ctrlT                 ctrl,
   output logic [dataWidth-1:0] imm
);

   logic [5:0] opcode;
   logic [5:0] funct;

   assign opcode = instr[31:26];
   assign funct  = instr[5:0];
   assign imm    = {{16{instr[15]}}, instr[15:0]};

   // Anything not listed stays a bubble, the zero word included
   always_comb begin
      ctrl = '0;
      unique case (opcode)
         opRType: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDstRd = 1'b1;
            case (funct)
               fnAddu: ctrl.aluOp = aluAdd;
               fnSubu: ctrl.aluOp = aluSub;
               fnAnd:  ctrl.aluOp = aluAnd;
               fnOr:   ctrl.aluOp = aluOr;
               fnSlt:  ctrl.aluOp = aluSlt;
               default: ctrl = '0;
            endcase
         end
         opAddiu: begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
         end
         opLw: begin
            ctrl.regWrite  = 1'b1;
            ctrl.memRead   = 1'b1;
            ctrl.memToReg  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
         end
         opSw: begin
            ctrl.memWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
         end
         opBeq: begin
            ctrl.isBranch = 1'b1;
            ctrl.aluOp    = aluSub;
         end
         default: ctrl = '0;
      endcase
   end

endmodule

// File: verilog/registerFile.sv
`timescale 1ns/1ps

module registerFile import mipsPkg::*; (
   input  logic                 Clk,
   input  logic                 rstN,
   input  logic [4:0]           rs,
   input  logic [4:0]           rt,
   input  logic                 wrEn,
   input  logic [4:0]           wrReg,
   input  logic [dataWidth-1:0] wrData,
   output logic [dataWidth-1:0] rsVal,
   output logic [dataWidth-1:0] rtVal
);

   // No storage behind register 0
   logic [dataWidth-1:0] regs [1:31];

   always_ff @(posedge Clk) begin
      if (!rstN) begin
         for (int i = 1; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && wrReg != 5'd0) begin
         regs[wrReg] <= wrData;
      end
   end

   // Write-through so decode sees this cycle's writeback
   always_comb begin
      rsVal = '0;
      rtVal = '0;
      if (rs != 5'd0) begin
         rsVal = (wrEn && wrReg == rs) ? wrData : regs[rs];
      end
      if (rt != 5'd0) begin
         rtVal = (wrEn && wrReg == rt) ? wrData : regs[rt];
      end
   end

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
   input  ifIdT       ifId,
   input  idExT       idEx,
   input  exMemT      exMem,
   input  memWbT      memWb,
   input  logic       operandsEqual,
   output logic       pcStall,
   output logic       ifIdStall,
   output logic       ifIdFlush,
   output logic       idExFlush,
   output logic       branchTaken,
   output logic [1:0] fwdA,
   output logic [1:0] fwdB
);

   logic loadUse;

   // Memory stage is younger, so it takes priority
   function automatic logic [1:0] fwdSel(input logic [4:0] src, input exMemT mem,
                                         input memWbT wb);
      if (mem.ctrl.regWrite && mem.destReg != 5'd0 && mem.destReg == src) begin
         return fwdSrcMem;
      end
      if (wb.regWrite && wb.destReg != 5'd0 && wb.destReg == src) begin
         return fwdSrcWb;
      end
      return fwdSrcReg;
   endfunction

   //////////////////////////////////////////////////
   // Stall and flush
   //////////////////////////////////////////////////
   // Load in execute feeding the instruction in decode
   assign loadUse = idEx.ctrl.memRead &&
                    (idEx.rt == ifId.instr[25:21] || idEx.rt == ifId.instr[20:16]);

   assign branchTaken = idEx.ctrl.isBranch && operandsEqual;

   assign pcStall   = loadUse;
   assign ifIdStall = loadUse;
   // Two younger instructions are dropped on a taken branch
   assign ifIdFlush = branchTaken;
   assign idExFlush = loadUse || branchTaken;

   //////////////////////////////////////////////////
   // Forwarding
   //////////////////////////////////////////////////
   always_comb begin
      fwdA = fwdSel(idEx.rs, exMem, memWb);
      fwdB = fwdSel(idEx.rt, exMem, memWb);
   end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu import mipsPkg::*; (
   input  aluOpT                op,
   input  logic [dataWidth-1:0] a,
   input  logic [dataWidth-1:0] b,
   output logic [dataWidth-1:0] result
);

   logic lessThan;

   // Signed compare for slt
   assign lessThan = $signed(a) < $signed(b);

   always_comb begin
      unique case (op)
         aluAdd: result = a + b;
         aluSub: result = a - b;
         aluAnd: result = a & b;
         aluOr:  result = a | b;
         aluSlt: result = {{(dataWidth-1){1'b0}}, lessThan};
         default: result = '0;
      endcase
   end

endmodule

// File: verilog/dataMemory.sv
`timescale 1ns/1ps

module dataMemory import mipsPkg::*; (
   input  logic                    Clk,
   input  logic                    wrEn,
   input  logic [memAddrWidth-1:0] addr,
   input  logic [dataWidth-1:0]    wrData,
   output logic [dataWidth-1:0]    rdData
);

   logic [dataWidth-1:0] mem [dmemDepth];

   // Word stores only
   always_ff @(posedge Clk) begin
      if (wrEn) begin
         mem[addr] <= wrData;
      end
   end

   // Asynchronous read
   assign rdData = mem[addr];

endmodule

// File: verilog/cpuTop.sv
`timescale 1ns/1ps

module cpuTop import mipsPkg::*; (
   input  logic                    Clk,
   input  logic                    rstN,
   input  logic                    progWe,
   input  logic [memAddrWidth-1:0] progAddr,
   input  logic [dataWidth-1:0]    progData,
   output logic                    wbValid,
   output logic [4:0]              wbRd,
   output logic [dataWidth-1:0]    wbData,
   output logic [dataWidth-1:0]    pcOut
);

   logic [dataWidth-1:0] pcF, pcPlus4F, instrF;
   logic [dataWidth-1:0] immD, rsValD, rtValD;
   logic [dataWidth-1:0] rsFwd, rtFwd, aluB, aluResultE, branchTarget;
   logic [dataWidth-1:0] loadDataM, wbDataW;
   logic [4:0]           destRegE;
   logic [1:0]           fwdA, fwdB;
   logic                 pcStall, ifIdStall, ifIdFlush, idExFlush;
   logic                 branchTaken, operandsEqual;
   ctrlT                 ctrlD;
   ifIdT                 ifIdD, ifIdQ;
   idExT                 idExD, idExQ;
   exMemT                exMemD, exMemQ;
   memWbT                memWbD, memWbQ;

   //////////////////////////////////////////////////
   // Fetch
   //////////////////////////////////////////////////
   fetchStage u_fetch (
      .Clk(Clk), .rstN(rstN), .pcStall(pcStall), .branchTaken(branchTaken),
      .branchTarget(branchTarget), .progWe(progWe), .progAddr(progAddr),
      .progData(progData), .pc(pcF), .pcPlus4(pcPlus4F), .instr(instrF)
   );

   assign ifIdD = '{pcPlus4: pcPlus4F, instr: instrF};

   pipeReg #(.payloadT(ifIdT)) ifIdReg (
      .Clk(Clk), .rstN(rstN), .stall(ifIdStall), .flush(ifIdFlush), .d(ifIdD), .q(ifIdQ)
   );

   //////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////
   decodeUnit u_decode (.instr(ifIdQ.instr), .ctrl(ctrlD), .imm(immD));

   registerFile u_regs (
      .Clk(Clk), .rstN(rstN), .rs(ifIdQ.instr[25:21]), .rt(ifIdQ.instr[20:16]),
      .wrEn(memWbQ.regWrite), .wrReg(memWbQ.destReg), .wrData(wbDataW),
      .rsVal(rsValD), .rtVal(rtValD)
   );

   assign idExD = '{ctrl: ctrlD, pcPlus4: ifIdQ.pcPlus4, rsVal: rsValD, rtVal: rtValD,
                    imm: immD, rs: ifIdQ.instr[25:21], rt: ifIdQ.instr[20:16],
                    rd: ifIdQ.instr[15:11]};

   pipeReg #(.payloadT(idExT)) idExReg (
      .Clk(Clk), .rstN(rstN), .stall(1'b0), .flush(idExFlush), .d(idExD), .q(idExQ)
   );

   hazardUnit u_hazard (
      .ifId(ifIdQ), .idEx(idExQ), .exMem(exMemQ), .memWb(memWbQ),
      .operandsEqual(operandsEqual), .pcStall(pcStall), .ifIdStall(ifIdStall),
      .ifIdFlush(ifIdFlush), .idExFlush(idExFlush), .branchTaken(branchTaken),
      .fwdA(fwdA), .fwdB(fwdB)
   );

   //////////////////////////////////////////////////
   // Execute
   //////////////////////////////////////////////////
   always_comb begin
      unique case (fwdA)
         fwdSrcMem: rsFwd = exMemQ.aluResult;
         fwdSrcWb:  rsFwd = wbDataW;
         default:   rsFwd = idExQ.rsVal;
      endcase
      unique case (fwdB)
         fwdSrcMem: rtFwd = exMemQ.aluResult;
         fwdSrcWb:  rtFwd = wbDataW;
         default:   rtFwd = idExQ.rtVal;
      endcase
   end

   assign aluB          = idExQ.ctrl.aluSrcImm ? idExQ.imm : rtFwd;
   assign destRegE      = idExQ.ctrl.regDstRd ? idExQ.rd : idExQ.rt;
   assign operandsEqual = (rsFwd == rtFwd);
   // Word offset relative to the delay-free pc+4
   assign branchTarget  = idExQ.pcPlus4 + {idExQ.imm[dataWidth-3:0], 2'b00};

   alu u_alu (.op(idExQ.ctrl.aluOp), .a(rsFwd), .b(aluB), .result(aluResultE));

   assign exMemD = '{ctrl: idExQ.ctrl, aluResult: aluResultE, storeData: rtFwd,
                     destReg: destRegE};

   pipeReg #(.payloadT(exMemT)) exMemReg (
      .Clk(Clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(exMemD), .q(exMemQ)
   );

   //////////////////////////////////////////////////
   // Memory and writeback
   //////////////////////////////////////////////////
   dataMemory u_dmem (
      .Clk(Clk), .wrEn(exMemQ.ctrl.memWrite), .addr(exMemQ.aluResult[memAddrWidth+1:2]),
      .wrData(exMemQ.storeData), .rdData(loadDataM)
   );

   assign memWbD = '{regWrite: exMemQ.ctrl.regWrite, memToReg: exMemQ.ctrl.memToReg,
                     aluResult: exMemQ.aluResult, loadData: loadDataM,
                     destReg: exMemQ.destReg};

   pipeReg #(.payloadT(memWbT)) memWbReg (
      .Clk(Clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(memWbD), .q(memWbQ)
   );

   assign wbDataW = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluResult;

   // Writes to register 0 are not reported
   assign wbValid = memWbQ.regWrite && memWbQ.destReg != 5'd0;
   assign wbRd    = memWbQ.destReg;
   assign wbData  = wbDataW;
   assign pcOut   = pcF;

endmodule

// File: dv/cpuTopTb.sv
`timescale 1ns/1ps

module cpuTopTb import mipsPkg::*; ();

   localparam int numEntries  = 5;
   localparam int maxWords    = 16;
   localparam int resetCycles = 8;
   localparam int clkPeriod   = 20;

   typedef struct packed {
      logic [4:0]           rd;
      logic [dataWidth-1:0] data;
   } wbExpT;

   logic                    Clk;
   logic                    rstN;
   logic                    progWe;
   logic [memAddrWidth-1:0] progAddr;
   logic [dataWidth-1:0]    progData;
   logic                    wbValid;
   logic [4:0]              wbRd;
   logic [dataWidth-1:0]    wbData;
   logic [dataWidth-1:0]    pcOut;

   // Program table and expected writebacks with one row per entry
   logic [dataWidth-1:0] progWords [numEntries][maxWords];
   wbExpT                expWb [numEntries][maxWords];
   int                   progLen [numEntries];
   int                   expCount [numEntries];
   integer               seed;
   int unsigned          watchdogNs = 0;

   cpuTop u_dut (
      .Clk(Clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData), .pcOut(pcOut)
   );

   initial begin
      Clk = 1'b0;
      forever #(clkPeriod / 2) Clk = ~Clk;
   end

   task automatic abortRun();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   //////////////////////////////////////////////////
   // Instruction encoding
   //////////////////////////////////////////////////
   function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                           input logic [4:0] rd, input logic [5:0] fn);
      return {opRType, rs, rt, rd, 5'd0, fn};
   endfunction

   function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   task automatic addInstr(input int e, input logic [31:0] word);
      progWords[e][progLen[e]] = word;
      progLen[e]++;
   endtask

   task automatic addExpect(input int e, input logic [4:0] rd, input logic [31:0] data);
      expWb[e][expCount[e]] = '{rd: rd, data: data};
      expCount[e]++;
   endtask

   task automatic buildTable();
      logic [31:0] rnd;
      logic [15:0] imm;
      logic [4:0]  src;
      logic [4:0]  dst;
      logic [31:0] acc;
      for (int e = 0; e < numEntries; e++) begin
         progLen[e]  = 0;
         expCount[e] = 0;
      end
      // Dependent chain with operands from memory and writeback stages
      addInstr(0, encodeI(opAddiu, 5'd0, 5'd1, 16'd5));
      addExpect(0, 5'd1, 32'd5);
      addInstr(0, encodeI(opAddiu, 5'd1, 5'd2, 16'd7));
      addExpect(0, 5'd2, 32'd12);
      addInstr(0, encodeR(5'd1, 5'd2, 5'd3, fnAddu));
      addExpect(0, 5'd3, 32'd17);
      addInstr(0, encodeR(5'd3, 5'd1, 5'd4, fnSubu));
      addExpect(0, 5'd4, 32'd12);
      addInstr(0, encodeR(5'd4, 5'd3, 5'd5, fnAnd));
      addExpect(0, 5'd5, 32'd0);
      addInstr(0, encodeR(5'd4, 5'd3, 5'd6, fnOr));
      addExpect(0, 5'd6, 32'd29);
      // Store and load back, then use the load at once
      addInstr(1, encodeI(opAddiu, 5'd0, 5'd1, 16'h1234));
      addExpect(1, 5'd1, 32'h1234);
      addInstr(1, encodeI(opAddiu, 5'd0, 5'd2, 16'd8));
      addExpect(1, 5'd2, 32'd8);
      addInstr(1, encodeI(opSw, 5'd2, 5'd1, 16'd4));
      addInstr(1, encodeI(opLw, 5'd2, 5'd3, 16'd4));
      addExpect(1, 5'd3, 32'h1234);
      addInstr(1, encodeR(5'd3, 5'd1, 5'd4, fnAddu));
      addExpect(1, 5'd4, 32'h2468);
      addInstr(1, encodeR(5'd4, 5'd3, 5'd5, fnAddu));
      addExpect(1, 5'd5, 32'h369c);
      // Taken beq skips two and the second beq falls through
      addInstr(2, encodeI(opAddiu, 5'd0, 5'd1, 16'd3));
      addExpect(2, 5'd1, 32'd3);
      addInstr(2, encodeI(opAddiu, 5'd0, 5'd2, 16'd3));
      addExpect(2, 5'd2, 32'd3);
      addInstr(2, encodeI(opBeq, 5'd1, 5'd2, 16'd2));
      addInstr(2, encodeI(opAddiu, 5'd0, 5'd3, 16'd1));
      addInstr(2, encodeI(opAddiu, 5'd0, 5'd4, 16'd2));
      addInstr(2, encodeI(opAddiu, 5'd0, 5'd5, 16'd9));
      addExpect(2, 5'd5, 32'd9);
      addInstr(2, encodeI(opBeq, 5'd1, 5'd5, 16'd1));
      addInstr(2, encodeI(opAddiu, 5'd0, 5'd6, 16'd4));
      addExpect(2, 5'd6, 32'd4);
      addInstr(2, encodeI(opAddiu, 5'd0, 5'd7, 16'd6));
      addExpect(2, 5'd7, 32'd6);
      // Register 0 stays zero and slt is signed
      addInstr(3, encodeI(opAddiu, 5'd0, 5'd1, 16'hfffc));
      addExpect(3, 5'd1, 32'hfffffffc);
      addInstr(3, encodeI(opAddiu, 5'd0, 5'd2, 16'd3));
      addExpect(3, 5'd2, 32'd3);
      addInstr(3, encodeI(opAddiu, 5'd0, 5'd0, 16'd7));
      addInstr(3, encodeR(5'd0, 5'd2, 5'd5, fnAddu));
      addExpect(3, 5'd5, 32'd3);
      addInstr(3, encodeR(5'd1, 5'd2, 5'd3, fnSlt));
      addExpect(3, 5'd3, 32'd1);
      addInstr(3, encodeR(5'd2, 5'd1, 5'd4, fnSlt));
      addExpect(3, 5'd4, 32'd0);
      // Seeded addiu chain where each step adds to the previous result
      seed = 32'h72426fab;
      acc  = '0;
      src  = 5'd0;
      for (int i = 0; i < 12; i++) begin
         rnd = $random(seed);
         imm = rnd[15:0];
         dst = 5'(i % 7 + 1);
         acc = acc + {{16{imm[15]}}, imm};
         addInstr(4, encodeI(opAddiu, src, dst, imm));
         addExpect(4, dst, acc);
         src = dst;
      end
   endtask

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////
   task automatic checkIdle();
      assert (wbValid === 1'b0) else begin
         $display("error: wbValid is %h, expected %h", wbValid, 1'b0);
         abortRun();
      end
      assert (pcOut === '0) else begin
         $display("error: pcOut is %h, expected %h", pcOut, 32'h0);
         abortRun();
      end
   endtask

   task automatic runEntry(input int e);
      int                   bound;
      int                   seen;
      logic [dataWidth-1:0] word;
      bound = (progLen[e] + 1) * 4 + 20;
      seen  = 0;
      @(posedge Clk);
      #2;
      rstN   = 1'b0;
      progWe = 1'b0;
      repeat (resetCycles) begin
         @(posedge Clk);
         @(negedge Clk);
         checkIdle();
      end
      // Whole memory rewritten and closed with a branch to itself
      for (int a = 0; a < imemDepth; a++) begin
         if (a < progLen[e]) begin
            word = progWords[e][a];
         end else if (a == progLen[e]) begin
            word = encodeI(opBeq, 5'd0, 5'd0, 16'hffff);
         end else begin
            word = '0;
         end
         @(posedge Clk);
         #2;
         progWe   = 1'b1;
         progAddr = a[memAddrWidth-1:0];
         progData = word;
         @(negedge Clk);
         checkIdle();
      end
      @(posedge Clk);
      #2;
      progWe = 1'b0;
      rstN   = 1'b1;
      @(negedge Clk);
      checkIdle();
      for (int c = 0; c < bound; c++) begin
         @(negedge Clk);
         if (wbValid === 1'b1) begin
            assert (seen < expCount[e]) else begin
               $display("program %0d wrote register %0d after its last expected writeback",
                        e, wbRd);
               abortRun();
            end
            assert (wbRd === expWb[e][seen].rd) else begin
               $display("error: wbRd is %h, expected %h", wbRd, expWb[e][seen].rd);
               abortRun();
            end
            assert (wbData === expWb[e][seen].data) else begin
               $display("error: wbData is %h, expected %h", wbData, expWb[e][seen].data);
               abortRun();
            end
            seen++;
         end
      end
      assert (seen == expCount[e]) else begin
         $display("program %0d retired only %0d of %0d writebacks in time",
                  e, seen, expCount[e]);
         abortRun();
      end
   endtask

   //////////////////////////////////////////////////
   // Main sequence and watchdog
   //////////////////////////////////////////////////
   initial begin
      int unsigned limitNs;
      rstN     = 1'b0;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      buildTable();
      limitNs = 50 * clkPeriod;
      for (int e = 0; e < numEntries; e++) begin
         limitNs += (resetCycles + imemDepth + 3 + (progLen[e] + 1) * 4 + 20) * clkPeriod;
      end
      watchdogNs = limitNs;
      for (int e = 0; e < numEntries; e++) begin
         runEntry(e);
      end
      $display("TEST PASSED");
      $finish;
   end

   initial begin
      wait (watchdogNs != 0);
      #(watchdogNs);
      $display("simulation ran past its time limit");
      abortRun();
   end

endmodule

// File: sim.f
verilog/mipsPkg.sv
verilog/pipeReg.sv
verilog/fetchStage.sv
verilog/decodeUnit.sv
verilog/registerFile.sv
verilog/hazardUnit.sv
verilog/alu.sv
verilog/dataMemory.sv
verilog/cpuTop.sv
dv/cpuTopTb.sv
